// File: src/fetch_config_pkg.sv
package fetch_config_pkg;

  // ******************************
  // fetch front end sizing
  // ******************************

  // log2 of the ring size in halfwords.
  localparam int default_prefetch_depth = 3;

  // ******************************
  // architectural constants
  // ******************************

  // pc after reset.
  localparam logic [31:0] reset_vector = 32'h0000_0000;

  // addi x0, x0, 0.
  localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage

// File: src/fetch_types_pkg.sv
package fetch_types_pkg;

  // ******************************
  // instruction memory port
  // ******************************

  // addr is always word aligned.
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } imem_rsp_t;

  // ******************************
  // control and delivery
  // ******************************

  // single cycle pulses, jump wins over fence.
  typedef struct packed {
    logic        jump;
    logic        fence;
    logic [31:0] target;
  } redirect_t;

  // compressed instructions are zero extended in instr.
  typedef struct packed {
    logic        valid;
    logic        compressed;
    logic [31:0] pc;
    logic [31:0] instr;
  } fetched_instr_t;

  typedef struct packed {
    logic [31:0] pc;
    logic        jump;
    logic        fence;
    logic        advance;
  } pc_ctrl_t;

endpackage

// File: src/halfword_ring.sv
`timescale 1ns/10ps

module halfword_ring
  import fetch_config_pkg::*;
#(
  parameter int prefetch_depth = default_prefetch_depth
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wr_en,
  input  logic [prefetch_depth-1:0] wr_idx,
  input  logic [31:0]               wr_data,
  input  logic [prefetch_depth-1:0] rd_idx,
  output logic [15:0]               rd_lo,
  output logic [15:0]               rd_hi
);

  logic [15:0] mem [2**prefetch_depth];

  // indices wrap by plain overflow.
  logic [prefetch_depth-1:0] wr_idx_next;
  logic [prefetch_depth-1:0] rd_idx_next;

  assign wr_idx_next = wr_idx + 1'b1;
  assign rd_idx_next = rd_idx + 1'b1;

  // one memory word lands as two halfwords.
  always_ff @(posedge clk) begin
    if (rst && wr_en) begin
      mem[wr_idx]      <= wr_data[15:0];
      mem[wr_idx_next] <= wr_data[31:16];
    end
  end

  assign rd_lo = mem[rd_idx];
  assign rd_hi = mem[rd_idx_next];

endmodule

// File: src/prefetch_buffer.sv
`timescale 1ns/10ps

module prefetch_buffer
  import fetch_config_pkg::*;
  import fetch_types_pkg::*;
#(
  parameter int prefetch_depth = default_prefetch_depth
) (
  input  logic        clk,
  input  logic        rst,
  input  pc_ctrl_t    pc_ctrl,
  input  imem_rsp_t   imem_rsp,
  output imem_req_t   imem_req,
  output logic [15:0] halfword_lo,
  output logic [15:0] halfword_hi,
  output logic        avail_lo,
  output logic        avail_hi
);

  localparam int ring_size = 2 ** prefetch_depth;

  logic [31:2]               fetch_ptr;
  logic [prefetch_depth-1:0] wr_idx;
  logic [prefetch_depth-1:0] rd_idx;
  logic [prefetch_depth:0]   count;
  logic [prefetch_depth:0]   count_next;
  logic                      skip;

  logic        redirect;
  logic        has_room;
  logic        accept;
  logic        wide;
  logic [1:0]  fill_hw;
  logic [1:0]  used_hw;
  logic [15:0] ring_lo;
  logic [15:0] ring_hi;

  // ******************************
  // memory request side
  // ******************************

  assign redirect = pc_ctrl.jump | pc_ctrl.fence;
  assign has_room = count <= (prefetch_depth + 1)'(ring_size - 2);

  // no request in a redirect cycle, the ring is about to be cleared.
  assign imem_req.valid = rst & has_room & ~redirect;
  assign imem_req.addr  = {fetch_ptr, 2'b00};

  assign accept = imem_req.valid & imem_rsp.ready;

  // ******************************
  // occupancy bookkeeping
  // ******************************

  assign wide = &halfword_lo[1:0];

  // after a redirect to an odd halfword the low half of the first word is dropped.
  assign fill_hw = accept ? (skip ? 2'd1 : 2'd2) : 2'd0;
  assign used_hw = pc_ctrl.advance ? (wide ? 2'd2 : 2'd1) : 2'd0;

  assign count_next = count + (prefetch_depth + 1)'(fill_hw)
                    - (prefetch_depth + 1)'(used_hw);

  always_ff @(posedge clk) begin
    if (!rst) begin
      fetch_ptr <= reset_vector[31:2];
      wr_idx    <= '0;
      rd_idx    <= prefetch_depth'(reset_vector[1]);
      count     <= '0;
      skip      <= reset_vector[1];
    end else if (redirect) begin
      // pc_ctrl.pc already carries the jump target here.
      fetch_ptr <= pc_ctrl.pc[31:2];
      wr_idx    <= '0;
      rd_idx    <= prefetch_depth'(pc_ctrl.pc[1]);
      count     <= '0;
      skip      <= pc_ctrl.pc[1];
    end else begin
      if (accept) begin
        fetch_ptr <= fetch_ptr + 1'b1;
        wr_idx    <= wr_idx + prefetch_depth'(2);
        skip      <= 1'b0;
      end
      rd_idx <= rd_idx + prefetch_depth'(used_hw);
      count  <= count_next;
    end
  end

  halfword_ring #(
    .prefetch_depth(prefetch_depth)
  ) halfword_ring_inst (
    .clk    (clk),
    .rst    (rst),
    .wr_en  (accept),
    .wr_idx (wr_idx),
    .wr_data(imem_rsp.rdata),
    .rd_idx (rd_idx),
    .rd_lo  (ring_lo),
    .rd_hi  (ring_hi)
  );

  // ******************************
  // halfword outputs with bypass
  // ******************************

  always_comb begin
    halfword_lo = ring_lo;
    halfword_hi = ring_hi;
    avail_lo    = 1'b0;
    avail_hi    = 1'b0;
    if (count == '0) begin
      // empty ring, take the arriving word directly.
      if (accept) begin
        avail_lo = 1'b1;
        if (pc_ctrl.pc[1]) begin
          halfword_lo = imem_rsp.rdata[31:16];
        end else begin
          halfword_lo = imem_rsp.rdata[15:0];
          halfword_hi = imem_rsp.rdata[31:16];
          avail_hi    = 1'b1;
        end
      end
    end else if (count == (prefetch_depth + 1)'(1)) begin
      // straddling case, upper half comes from the new word.
      avail_lo = 1'b1;
      if (accept) begin
        halfword_hi = imem_rsp.rdata[15:0];
        avail_hi    = 1'b1;
      end
    end else begin
      avail_lo = 1'b1;
      avail_hi = 1'b1;
    end
  end

endmodule

// File: src/fetch_sequencer.sv
`timescale 1ns/10ps

module fetch_sequencer
  import fetch_config_pkg::*;
  import fetch_types_pkg::*;
(
  input  logic           clk,
  input  logic           rst,
  input  redirect_t      redirect,
  input  logic [15:0]    halfword_lo,
  input  logic [15:0]    halfword_hi,
  input  logic           avail_lo,
  input  logic           avail_hi,
  output pc_ctrl_t       pc_ctrl,
  output fetched_instr_t fetched
);

  logic [31:0] pc;
  logic        do_jump;
  logic        do_fence;
  logic        is_compressed;
  logic        instr_ready;
  logic        deliver;

  // ******************************
  // length decode and delivery
  // ******************************

  assign do_jump  = redirect.jump;
  assign do_fence = redirect.fence & ~redirect.jump;

  assign is_compressed = halfword_lo[1:0] != 2'b11;
  assign instr_ready   = avail_lo & (is_compressed | avail_hi);

  // nothing is delivered while redirecting.
  assign deliver = instr_ready & ~do_jump & ~do_fence;

  assign fetched.valid      = deliver;
  assign fetched.compressed = deliver & is_compressed;
  assign fetched.pc         = pc;

  always_comb begin
    fetched.instr = nop_instr;
    if (deliver) begin
      if (is_compressed) begin
        fetched.instr = {16'h0000, halfword_lo};
      end else begin
        fetched.instr = {halfword_hi, halfword_lo};
      end
    end
  end

  // the buffer realigns to the target, so it sees it a cycle early.
  assign pc_ctrl.pc      = do_jump ? redirect.target : pc;
  assign pc_ctrl.jump    = do_jump;
  assign pc_ctrl.fence   = do_fence;
  assign pc_ctrl.advance = deliver;

  // ******************************
  // program counter
  // ******************************

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc <= reset_vector;
    end else if (do_jump) begin
      pc <= redirect.target;
    end else if (deliver) begin
      pc <= pc + (is_compressed ? 32'd2 : 32'd4);
    end
  end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit
  import fetch_config_pkg::*;
  import fetch_types_pkg::*;
#(
  parameter int prefetch_depth = default_prefetch_depth
) (
  input  logic           clk,
  input  logic           rst,
  input  imem_rsp_t      imem_rsp,
  input  redirect_t      redirect,
  output imem_req_t      imem_req,
  output fetched_instr_t fetched
);

  pc_ctrl_t    pc_ctrl;
  logic [15:0] halfword_lo;
  logic [15:0] halfword_hi;
  logic        avail_lo;
  logic        avail_hi;

  // ******************************
  // pc and delivery
  // ******************************

  fetch_sequencer fetch_sequencer_inst (
    .clk        (clk),
    .rst        (rst),
    .redirect   (redirect),
    .halfword_lo(halfword_lo),
    .halfword_hi(halfword_hi),
    .avail_lo   (avail_lo),
    .avail_hi   (avail_hi),
    .pc_ctrl    (pc_ctrl),
    .fetched    (fetched)
  );

  // ******************************
  // prefetch ring and memory port
  // ******************************

  prefetch_buffer #(
    .prefetch_depth(prefetch_depth)
  ) prefetch_buffer_inst (
    .clk        (clk),
    .rst        (rst),
    .pc_ctrl    (pc_ctrl),
    .imem_rsp   (imem_rsp),
    .imem_req   (imem_req),
    .halfword_lo(halfword_lo),
    .halfword_hi(halfword_hi),
    .avail_lo   (avail_lo),
    .avail_hi   (avail_hi)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period       = 40,
  parameter int reset_cycles = 8,
  parameter int drive_delay  = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

  // active low, released just after an edge.
  initial begin
    rst = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #drive_delay;
    rst = 1'b1;
  end

endmodule

// File: verification/fetch_unit_properties.sv
`timescale 1ns/10ps

module fetch_unit_properties
  import fetch_types_pkg::*;
(
  input logic           clk,
  input logic           rst,
  input imem_req_t      imem_req,
  input imem_rsp_t      imem_rsp,
  input redirect_t      redirect,
  input fetched_instr_t fetched
);

  // fetch pointer holds while the memory stalls.
  addr_stable_on_stall: assert property (
    @(posedge clk) disable iff (!rst)
    imem_req.valid && !imem_rsp.ready |=> $stable(imem_req.addr)
  ) else $error("imem_req.addr moved while the memory was stalling");

  // a jump refetches from the word that holds the target.
  addr_realigned_on_jump: assert property (
    @(posedge clk) disable iff (!rst)
    redirect.jump |=> imem_req.addr == {$past(redirect.target[31:2]), 2'b00}
  ) else $error("imem_req.addr is not the word of the jump target after a jump");

  no_delivery_in_reset: assert property (
    @(posedge clk) !rst |-> !fetched.valid
  ) else $error("fetched.valid was high during reset");

  // jump loads the target, fence keeps the pc.
  pc_after_redirect: assert property (
    @(posedge clk) disable iff (!rst)
    (redirect.jump || redirect.fence) |=>
      fetched.pc == ($past(redirect.jump) ? $past(redirect.target) : $past(fetched.pc))
  ) else $error("fetched.pc is wrong in the cycle after a redirect");

endmodule

// File: verification/fetch_unit_tb.sv
`timescale 1ns/10ps

module fetch_unit_tb
  import fetch_config_pkg::*;
  import fetch_types_pkg::*;
();

  localparam int clk_period      = 40;
  localparam int reset_cycles    = 8;
  localparam int drive_delay     = 2;
  localparam int random_seed     = 29459;
  localparam int prog_aw         = 8;
  localparam int prog_words      = 2 ** prog_aw;
  localparam int rewrite_words   = 32;
  localparam int num_rows        = 6;
  localparam int cycles_per_row  = 400;
  localparam int watchdog_cycles = cycles_per_row * num_rows + 200;

  typedef enum logic [1:0] {
    redir_none,
    redir_jump,
    redir_fence
  } redir_kind_t;

  typedef struct packed {
    int          ready_pct;
    redir_kind_t kind;
    logic [31:0] target;
    int          fire_after;
    logic        rewrite;
    int          total;
  } stim_row_t;

  logic           clk;
  logic           rst;
  logic           rsp_ready;
  imem_req_t      imem_req;
  imem_rsp_t      imem_rsp;
  redirect_t      redirect;
  fetched_instr_t fetched;

  logic [31:0] prog [prog_words];
  stim_row_t   stim_table [num_rows];
  string       phase_names [num_rows];
  logic [31:0] exp_pc;
  int          error_count;
  int          check_count;
  int          delivered_total;

  tb_clock_gen #(
    .period      (clk_period),
    .reset_cycles(reset_cycles),
    .drive_delay (drive_delay)
  ) tb_clock_gen_inst (
    .clk(clk),
    .rst(rst)
  );

  fetch_unit #(
    .prefetch_depth(default_prefetch_depth)
  ) fetch_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .imem_rsp(imem_rsp),
    .redirect(redirect),
    .imem_req(imem_req),
    .fetched (fetched)
  );

  bind fetch_unit fetch_unit_properties fetch_unit_properties_inst (
    .clk     (clk),
    .rst     (rst),
    .imem_req(imem_req),
    .imem_rsp(imem_rsp),
    .redirect(redirect),
    .fetched (fetched)
  );

  // memory answers the current address combinationally.
  assign imem_rsp = {rsp_ready, prog[imem_req.addr[prog_aw+1:2]]};

  // ******************************
  // program image and walker
  // ******************************

  function automatic logic [31:0] fill_word(input logic [31:0] addr, input logic [7:0] variant);
    logic [31:0] x;
    x = (addr ^ {variant, 24'h00_0000}) * 32'h9e37_79b1;
    x = x ^ (x >> 15);
    return x;
  endfunction

  function automatic logic [15:0] halfword_at(input logic [31:0] addr);
    logic [31:0] word;
    word = prog[addr[prog_aw+1:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // length from the two low bits of the first halfword.
  function automatic fetched_instr_t predict_at(input logic [31:0] pc);
    fetched_instr_t want;
    logic [15:0]    lo;
    lo         = halfword_at(pc);
    want.valid = 1'b1;
    want.pc    = pc;
    if (lo[1:0] == 2'b11) begin
      want.compressed = 1'b0;
      want.instr      = {halfword_at(pc + 32'd2), lo};
    end else begin
      want.compressed = 1'b1;
      want.instr      = {16'h0000, lo};
    end
    return want;
  endfunction

  task automatic load_program();
    for (int i = 0; i < prog_words; i++) begin
      prog[i] = fill_word(32'(i * 4), 8'd0);
    end
  endtask

  task automatic load_table();
    phase_names[0] = "straight";
    stim_table[0]  = '{ready_pct: 100, kind: redir_none, target: 32'h0000_0000,
                       fire_after: 0, rewrite: 1'b0, total: 40};
    phase_names[1] = "backpressure";
    stim_table[1]  = '{ready_pct: 30, kind: redir_none, target: 32'h0000_0000,
                       fire_after: 0, rewrite: 1'b0, total: 40};
    phase_names[2] = "jump_aligned";
    stim_table[2]  = '{ready_pct: 70, kind: redir_jump, target: 32'h0000_0100,
                       fire_after: 5, rewrite: 1'b0, total: 20};
    phase_names[3] = "jump_odd_halfword";
    stim_table[3]  = '{ready_pct: 60, kind: redir_jump, target: 32'h0000_01a6,
                       fire_after: 5, rewrite: 1'b0, total: 20};
    phase_names[4] = "fence_rewrite";
    stim_table[4]  = '{ready_pct: 50, kind: redir_fence, target: 32'h0000_0000,
                       fire_after: 6, rewrite: 1'b1, total: 20};
    phase_names[5] = "jump_low";
    stim_table[5]  = '{ready_pct: 30, kind: redir_jump, target: 32'h0000_0042,
                       fire_after: 3, rewrite: 1'b0, total: 15};
  endtask

  // ******************************
  // compare tasks
  // ******************************

  task automatic check_fetched(input fetched_instr_t got, input fetched_instr_t want);
    check_count++;
    if (got.valid !== want.valid) begin
      error_count++;
      $display("CHECK FAILED fetched.valid got %h exp %h at %0t",
               got.valid, want.valid, $time);
    end else begin
      if (want.valid && got.pc !== want.pc) begin
        error_count++;
        $display("CHECK FAILED fetched.pc got %h exp %h at %0t", got.pc, want.pc, $time);
      end
      if (got.instr !== want.instr) begin
        error_count++;
        $display("CHECK FAILED fetched.instr got %h exp %h at %0t",
                 got.instr, want.instr, $time);
      end
      if (got.compressed !== want.compressed) begin
        error_count++;
        $display("CHECK FAILED fetched.compressed got %h exp %h at %0t",
                 got.compressed, want.compressed, $time);
      end
    end
  endtask

  task automatic check_req(input imem_req_t got, input imem_req_t want);
    check_count++;
    if (got.valid !== want.valid) begin
      error_count++;
      $display("CHECK FAILED imem_req.valid got %h exp %h at %0t",
               got.valid, want.valid, $time);
    end
    if (got.addr !== want.addr) begin
      error_count++;
      $display("CHECK FAILED imem_req.addr got %h exp %h at %0t",
               got.addr, want.addr, $time);
    end
  endtask

  task automatic take_delivery();
    fetched_instr_t want;
    want = predict_at(exp_pc);
    check_fetched(fetched, want);
    exp_pc = exp_pc + (want.compressed ? 32'd2 : 32'd4);
    delivered_total++;
  endtask

  // a fence rewrites memory from the current pc before it fires.
  task automatic fire_redirect(input stim_row_t row);
    logic [31:0] addr;
    if (row.kind == redir_jump) begin
      redirect.jump   = 1'b1;
      redirect.target = row.target;
      exp_pc          = row.target;
    end else begin
      if (row.rewrite) begin
        for (int i = 0; i < rewrite_words; i++) begin
          addr = {exp_pc[31:2], 2'b00} + 32'(4 * i);
          prog[addr[prog_aw+1:2]] = fill_word(addr, 8'd1);
        end
      end
      redirect.fence = 1'b1;
    end
  endtask

  // ******************************
  // stimulus and verdict
  // ******************************

  initial begin : main_sequence
    stim_row_t      row;
    fetched_instr_t idle;
    imem_req_t      req_want;
    int             delivered;
    logic           fired;
    logic           in_redirect;

    rsp_ready       = 1'b0;
    redirect        = '0;
    error_count     = 0;
    check_count     = 0;
    delivered_total = 0;
    exp_pc          = reset_vector;
    // nothing delivered shows the nop.
    idle            = '0;
    idle.instr      = nop_instr;
    void'($urandom(random_seed));
    load_table();
    load_program();

    repeat (reset_cycles / 2) @(negedge clk);
    req_want = '{valid: 1'b0, addr: reset_vector};
    check_fetched(fetched, idle);
    check_req(imem_req, req_want);

    // first cycle out of reset, memory still stalled.
    @(posedge rst);
    @(negedge clk);
    req_want.valid = 1'b1;
    check_fetched(fetched, idle);
    check_req(imem_req, req_want);
    @(posedge clk);
    #drive_delay;

    for (int r = 0; r < num_rows; r++) begin
      row       = stim_table[r];
      delivered = 0;
      fired     = (row.kind == redir_none);
      $display("phase %0s", phase_names[r]);
      while (delivered < row.total || !fired) begin
        redirect    = '0;
        rsp_ready   = int'($urandom % 100) < row.ready_pct;
        in_redirect = 1'b0;
        if (!fired && delivered == row.fire_after) begin
          fire_redirect(row);
          fired       = 1'b1;
          in_redirect = 1'b1;
        end
        @(negedge clk);
        if (in_redirect) begin
          check_fetched(fetched, idle);
        end else if (fetched.valid) begin
          take_delivery();
          delivered++;
        end
        @(posedge clk);
        #drive_delay;
      end
    end
    redirect = '0;

    $display("checks: %0d, errors: %0d, deliveries: %0d",
             check_count, error_count, delivered_total);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("timeout after %0d cycles, the fetch stream stopped making progress",
             watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: sources.f
src/fetch_config_pkg.sv
src/fetch_types_pkg.sv
src/halfword_ring.sv
src/prefetch_buffer.sv
src/fetch_sequencer.sv
src/fetch_unit.sv
verification/tb_clock_gen.sv
verification/fetch_unit_properties.sv
verification/fetch_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module fetch_unit_tb \
    -Mdir obj_dir -o fetch_unit_sim -f sources.f; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/fetch_unit_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
